/* fe_top.f */
+incdir+include
source/fe_pkg.sv
source/fe_cmd_decode.sv
source/fe_pc_gen.sv
source/fe_imem_bank.sv
source/fe_queue_collector.sv
source/fe_top.sv
test/fe_tb_pkg.sv
test/fe_top_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the front-end testbench with Verilator
cd "$(dirname "$0")" \
  && verilator --binary --timing -f fe_top.f --top-module fe_top_tb -Mdir build/obj_dir \
  && ./build/obj_dir/Vfe_top_tb \
  || { echo "Simulation did not complete cleanly"; exit 1; }

/* test/fe_top_tb.sv */
// ----------------------------------------
// Front-end testbench
// ----------------------------------------

`timescale 1ns/1ps

`include "fe_settings.svh"

module fe_top_tb;

  localparam int cycle_limit = 4000;

  logic clk_i, reset_i, fe_cmd_v_i, fe_cmd_yumi_o, fe_queue_v_o, credit_return_i;
  fe_pkg::fe_cmd_s       fe_cmd_i;
  fe_pkg::fe_queue_msg_s fe_queue_o;

  int cycle = 0, msg_count = 0, exc_count = 0, outstanding = 0, park_cycle = 0;
  int seed = 15;
  int return_due[$];
  bit hold_credits = 0, halted = 0, parked = 0, have_last = 0, target_seen = 0;
  logic [`VADDR_WIDTH-1:0] last_pc, redirect_target;

  fe_top UUT
    (.clk_i            (clk_i)
     ,.reset_i         (reset_i)
     ,.fe_cmd_i        (fe_cmd_i)
     ,.fe_cmd_v_i      (fe_cmd_v_i)
     ,.fe_cmd_yumi_o   (fe_cmd_yumi_o)
     ,.fe_queue_o      (fe_queue_o)
     ,.fe_queue_v_o    (fe_queue_v_o)
     ,.credit_return_i (credit_return_i)
     );

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Test failures found");
    $fatal(1);
  endtask

  initial
  begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  always @(posedge clk_i)
  begin
    cycle <= cycle + 1;
    if (cycle >= cycle_limit)
      fail_run("Run timed out waiting for the front end");
  end

  // Credit returns and message checks run on the falling edge
  always @(negedge clk_i)
  begin
    fe_pkg::fe_queue_msg_s got, exp;
    logic [`VADDR_WIDTH-1:0] pc;
    bit ok;
    credit_return_i = 1'b0;
    if (!hold_credits && return_due.size() > 0 && return_due[0] <= cycle)
    begin
      void'(return_due.pop_front());
      credit_return_i = 1'b1;
      outstanding--;
    end
    if (!reset_i && fe_queue_v_o)
    begin
      got = fe_queue_o;
      pc  = got.payload.fetch.pc;
      if (halted)
        fail_run("A message arrived after a fault without a new redirect");
      if (parked && cycle > park_cycle + 3)
        fail_run("A message arrived too long after a park");
      if (!(have_last && pc == last_pc + 4) && (target_seen || pc != redirect_target))
      begin
        $display("MISMATCH at %0t: unexpected pc %h after %h, target %h",
                 $time, pc, last_pc, redirect_target);
        fail_run("Message pc is off the fetch path");
      end
      if (pc == redirect_target)
        target_seen = 1;
      exp = fe_tb_pkg::expected_msg(pc);
      if (exp.msg_type == fe_pkg::e_msg_exception)
        fe_tb_pkg::check_exception(got, exp, ok);
      else
        fe_tb_pkg::check_fetch(got, exp, ok);
      if (!ok)
        fail_run("Message content differs from the reference");
      if (exp.msg_type == fe_pkg::e_msg_exception)
      begin
        halted = 1;
        exc_count++;
      end
      last_pc   = pc;
      have_last = 1;
      msg_count++;
      outstanding++;
      if (outstanding > `QUEUE_CREDITS)
        fail_run("More messages delivered than the queue has credits");
      return_due.push_back(cycle + 1 + ($random(seed) & 1));
    end
  end

  task automatic send_cmd(input fe_pkg::fe_opcode_e op, input logic [`VADDR_WIDTH-1:0] vaddr,
                          input logic [`INSTR_WIDTH-1:0] instr);
    bit taken;
    @(negedge clk_i);
    fe_cmd_i   = '{opcode: op, vaddr: vaddr, instr: instr};
    fe_cmd_v_i = 1'b1;
    if (op == fe_pkg::e_op_redirect)
    begin
      redirect_target = vaddr;
      target_seen     = 0;
      halted          = 0;
      parked          = 0;
    end
    else if (op == fe_pkg::e_op_park)
    begin
      parked     = 1;
      park_cycle = cycle;
    end
    else
      fe_tb_pkg::ref_mem[int'(vaddr >> 2)] = instr;
    // Command is taken on the rising edge where yumi is high
    taken = 0;
    while (!taken)
    begin
      @(posedge clk_i);
      taken = fe_cmd_yumi_o;
    end
    @(negedge clk_i);
    fe_cmd_v_i = 1'b0;
  endtask

  task automatic wait_messages(input int n);
    int target;
    target = msg_count + n;
    while (msg_count < target)
      @(negedge clk_i);
  endtask

  task automatic wait_exception();
    int target;
    target = exc_count + 1;
    while (exc_count < target)
      @(negedge clk_i);
  endtask

  initial
  begin
    reset_i         = 1'b1;
    fe_cmd_v_i      = 1'b0;
    fe_cmd_i        = '0;
    credit_return_i = 1'b0;
    repeat (16) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;

    for (int w = 0; w < `IMEM_BANKS * `BANK_WORDS; w++)
      send_cmd(fe_pkg::e_op_fill, w * 4, $random(seed));
    send_cmd(fe_pkg::e_op_redirect, 0, '0);
    wait_exception();
    repeat (10) @(negedge clk_i);

    send_cmd(fe_pkg::e_op_redirect, 32'h22, '0);
    wait_exception();

    send_cmd(fe_pkg::e_op_redirect, 0, '0);
    wait_messages(10);
    send_cmd(fe_pkg::e_op_redirect, 32'h80, '0);
    wait_exception();

    hold_credits = 1;
    send_cmd(fe_pkg::e_op_redirect, 0, '0);
    repeat (20) @(negedge clk_i);
    hold_credits = 0;
    wait_exception();

    send_cmd(fe_pkg::e_op_redirect, 0, '0);
    wait_messages(6);
    send_cmd(fe_pkg::e_op_park, 0, '0);
    repeat (10) @(negedge clk_i);
    send_cmd(fe_pkg::e_op_fill, 32'h8, $random(seed));
    send_cmd(fe_pkg::e_op_redirect, 32'h8, '0);
    wait_exception();

    while (outstanding > 0)
      @(negedge clk_i);
    $display("All tests passed!");
    $finish;
  end

endmodule

/* test/fe_tb_pkg.sv */
// ----------------------------------------
// Front-end reference model
// ----------------------------------------

`include "fe_settings.svh"

package fe_tb_pkg;

  // Mirror of the instruction store that fill commands update
  logic [`INSTR_WIDTH-1:0] ref_mem [`IMEM_BANKS * `BANK_WORDS];

  function automatic fe_pkg::fe_queue_msg_s expected_msg(input logic [`VADDR_WIDTH-1:0] pc);
    fe_pkg::fe_queue_msg_s   msg;
    logic [`VADDR_WIDTH-1:0] limit;
    limit = `IMEM_BANKS * `BANK_WORDS * 4;
    msg   = '0;
    if (pc[1:0] != 2'b00 || pc >= limit)
    begin
      msg.msg_type                = fe_pkg::e_msg_exception;
      msg.payload.exception.pc    = pc;
      msg.payload.exception.fault = (pc[1:0] != 2'b00) ? fe_pkg::e_fault_misaligned
                                                         : fe_pkg::e_fault_access;
    end
    else
    begin
      msg.msg_type            = fe_pkg::e_msg_fetch;
      msg.payload.fetch.pc    = pc;
      msg.payload.fetch.instr = ref_mem[int'(pc >> 2)];
    end
    return msg;
  endfunction

  task automatic check_fetch(input fe_pkg::fe_queue_msg_s got, input fe_pkg::fe_queue_msg_s exp,
                             output bit ok);
    ok = (got.msg_type == exp.msg_type) && (got.payload.fetch == exp.payload.fetch);
    if (!ok)
      $display("MISMATCH at %0t: fetch type %0d pc %h instr %h, expected pc %h instr %h",
               $time, got.msg_type, got.payload.fetch.pc, got.payload.fetch.instr,
               exp.payload.fetch.pc, exp.payload.fetch.instr);
  endtask

  task automatic check_exception(input fe_pkg::fe_queue_msg_s got,
                                 input fe_pkg::fe_queue_msg_s exp, output bit ok);
    ok = (got.msg_type == exp.msg_type) && (got.payload.exception == exp.payload.exception);
    if (!ok)
      $display("MISMATCH at %0t: exception type %0d pc %h fault %0d, expected pc %h fault %0d",
               $time, got.msg_type, got.payload.exception.pc, got.payload.exception.fault,
               exp.payload.exception.pc, exp.payload.exception.fault);
  endtask

endpackage

/* source/fe_top.sv */
// ----------------------------------------
// Instruction fetch front end
// ----------------------------------------

`timescale 1ns/1ps

`include "fe_settings.svh"

module fe_top
  (input  logic                          clk_i
   , input  logic                        reset_i

   , input  fe_pkg::fe_cmd_s             fe_cmd_i
   , input  logic                        fe_cmd_v_i
   , output logic                        fe_cmd_yumi_o

   , output fe_pkg::fe_queue_msg_s       fe_queue_o
   , output logic                        fe_queue_v_o
   , input  logic                        credit_return_i
   );

  logic                                     redirect_v;
  logic [`VADDR_WIDTH-1:0]                  redirect_pc;
  logic                                     park_v;
  logic                                     release_v;
  fe_pkg::fe_fill_s                         fill;
  fe_pkg::fe_fetch_req_s                    fetch_req;
  fe_pkg::fe_bank_resp_s [`IMEM_BANKS-1:0]  bank_resp;

  fe_cmd_decode cmd_decode
    (.clk_i          (clk_i)
     ,.reset_i       (reset_i)
     ,.fe_cmd_i      (fe_cmd_i)
     ,.fe_cmd_v_i    (fe_cmd_v_i)
     ,.fe_cmd_yumi_o (fe_cmd_yumi_o)
     ,.redirect_v_o  (redirect_v)
     ,.redirect_pc_o (redirect_pc)
     ,.fill_o        (fill)
     ,.park_v_o      (park_v)
     );

  fe_pc_gen pc_gen
    (.clk_i            (clk_i)
     ,.reset_i         (reset_i)
     ,.redirect_v_i    (redirect_v)
     ,.redirect_pc_i   (redirect_pc)
     ,.park_v_i        (park_v)
     ,.credit_return_i (credit_return_i)
     ,.release_i       (release_v)
     ,.fetch_req_o     (fetch_req)
     );

  // Fill and fetch go to every bank and each bank keeps its own slice
  for (genvar i = 0; i < `IMEM_BANKS; i++)
  begin : g_bank
    fe_imem_bank #(.BANK_ID(i)) bank
      (.clk_i        (clk_i)
       ,.reset_i     (reset_i)
       ,.fill_i      (fill)
       ,.fetch_req_i (fetch_req)
       ,.bank_resp_o (bank_resp[i])
       );
  end

  // Redirect pulse flushes the response stage
  fe_queue_collector collector
    (.clk_i         (clk_i)
     ,.reset_i      (reset_i)
     ,.bank_resp_i  (bank_resp)
     ,.flush_i      (redirect_v)
     ,.release_o    (release_v)
     ,.fe_queue_o   (fe_queue_o)
     ,.fe_queue_v_o (fe_queue_v_o)
     );

endmodule

/* source/fe_queue_collector.sv */
// ----------------------------------------
// Fetch queue collector
// ----------------------------------------

`timescale 1ns/1ps

`include "fe_settings.svh"

module fe_queue_collector
  (input  logic                                     clk_i
   , input  logic                                   reset_i

   , input  fe_pkg::fe_bank_resp_s [`IMEM_BANKS-1:0] bank_resp_i
   , input  logic                                   flush_i
   , output logic                                   release_o

   , output fe_pkg::fe_queue_msg_s                  fe_queue_o
   , output logic                                   fe_queue_v_o
   );

  fe_pkg::fe_bank_resp_s sel_resp;
  fe_pkg::fe_queue_msg_s msg_n, msg_r;
  logic                  any_v;
  logic                  queue_v_r;

  // At most one bank answers in a cycle
  always_comb
  begin
    sel_resp = '0;
    any_v    = 1'b0;
    for (int i = 0; i < `IMEM_BANKS; i++)
    begin
      if (bank_resp_i[i].v)
      begin
        sel_resp = bank_resp_i[i];
        any_v    = 1'b1;
      end
    end
  end

  // Flushed fetch hands its credit back
  assign release_o = any_v & flush_i;

  always_comb
  begin
    msg_n = '0;
    if (sel_resp.fault != fe_pkg::e_fault_none)
    begin
      msg_n.msg_type                = fe_pkg::e_msg_exception;
      msg_n.payload.exception.pc    = sel_resp.pc;
      msg_n.payload.exception.fault = sel_resp.fault;
      msg_n.payload.exception.pad   = '0;
    end
    else
    begin
      msg_n.msg_type            = fe_pkg::e_msg_fetch;
      msg_n.payload.fetch.pc    = sel_resp.pc;
      msg_n.payload.fetch.instr = sel_resp.instr;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      queue_v_r <= 1'b0;
    else
      queue_v_r <= any_v & ~flush_i;
  end

  always_ff @(posedge clk_i)
  begin
    msg_r <= msg_n;
  end

  assign fe_queue_o   = msg_r;
  assign fe_queue_v_o = queue_v_r;

endmodule

/* source/fe_imem_bank.sv */
// ----------------------------------------
// Interleaved instruction bank
// ----------------------------------------

`timescale 1ns/1ps

`include "fe_settings.svh"

module fe_imem_bank
  #(parameter int BANK_ID = 0)
  (input  logic                          clk_i
   , input  logic                        reset_i

   , input  fe_pkg::fe_fill_s            fill_i
   , input  fe_pkg::fe_fetch_req_s       fetch_req_i
   , output fe_pkg::fe_bank_resp_s       bank_resp_o
   );

  localparam int bank_bits = $clog2(`IMEM_BANKS);
  localparam int word_bits = $clog2(`BANK_WORDS);
  localparam logic [bank_bits-1:0] bank_sel = BANK_ID[bank_bits-1:0];

  logic [`INSTR_WIDTH-1:0] mem_r [`BANK_WORDS];

  logic [bank_bits-1:0] fill_bank, fetch_bank;
  logic [word_bits-1:0] fill_word, fetch_word;
  logic                 resp_v_r;
  logic [`VADDR_WIDTH-1:0] resp_pc_r;
  logic [`INSTR_WIDTH-1:0] resp_instr_r;
  fe_pkg::fe_fault_e       resp_fault_r;

  // Byte offset, then bank select, then word index
  assign fill_bank  = fill_i.addr[2 +: bank_bits];
  assign fill_word  = fill_i.addr[2 + bank_bits +: word_bits];
  assign fetch_bank = fetch_req_i.pc[2 +: bank_bits];
  assign fetch_word = fetch_req_i.pc[2 + bank_bits +: word_bits];

  always_ff @(posedge clk_i)
  begin
    if (fill_i.v && (fill_bank == bank_sel))
      mem_r[fill_word] <= fill_i.instr;
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      resp_v_r <= 1'b0;
    else
      resp_v_r <= fetch_req_i.v & (fetch_bank == bank_sel);
  end

  // Out-of-range PCs still read a wrapped word
  always_ff @(posedge clk_i)
  begin
    resp_pc_r    <= fetch_req_i.pc;
    resp_instr_r <= mem_r[fetch_word];
    resp_fault_r <= fetch_req_i.fault;
  end

  assign bank_resp_o = '{v: resp_v_r, pc: resp_pc_r, instr: resp_instr_r, fault: resp_fault_r};

endmodule

/* source/fe_pc_gen.sv */
// ----------------------------------------
// PC generator and fetch control
// ----------------------------------------

`timescale 1ns/1ps

`include "fe_settings.svh"

module fe_pc_gen
  (input  logic                          clk_i
   , input  logic                        reset_i

   , input  logic                        redirect_v_i
   , input  logic [`VADDR_WIDTH-1:0]     redirect_pc_i
   , input  logic                        park_v_i

   , input  logic                        credit_return_i
   , input  logic                        release_i

   , output fe_pkg::fe_fetch_req_s       fetch_req_o
   );

  localparam int credit_bits = $clog2(`QUEUE_CREDITS + 1);
  localparam logic [`VADDR_WIDTH-1:0] imem_bytes = `IMEM_BANKS * `BANK_WORDS * 4;

  enum logic {e_wait = 1'b0, e_run = 1'b1} state_r, state_n;

  logic [`VADDR_WIDTH-1:0] pc_r, pc_n;
  logic [`VADDR_WIDTH-1:0] issue_pc;
  logic [credit_bits-1:0]  credits_r, credits_n;
  logic                    issue;
  fe_pkg::fe_fault_e       issue_fault;

  // A redirect starts its own target in the same cycle
  assign issue_pc = redirect_v_i ? redirect_pc_i : pc_r;
  assign issue    = ((state_r == e_run) | redirect_v_i) & ~park_v_i & (credits_r != '0);

  always_comb
  begin
    if (issue_pc[1:0] != 2'b00)
      issue_fault = fe_pkg::e_fault_misaligned;
    else if (issue_pc >= imem_bytes)
      issue_fault = fe_pkg::e_fault_access;
    else
      issue_fault = fe_pkg::e_fault_none;
  end

  always_comb
  begin
    state_n = state_r;
    if (redirect_v_i)
      state_n = e_run;
    else if (park_v_i)
      state_n = e_wait;
    // Faulting fetch parks the front end until the next redirect
    if (issue & (issue_fault != fe_pkg::e_fault_none))
      state_n = e_wait;
  end

  assign pc_n = issue ? issue_pc + `VADDR_WIDTH'(4) : issue_pc;

  assign credits_n = credits_r
                     - credit_bits'(issue)
                     + credit_bits'(credit_return_i)
                     + credit_bits'(release_i);

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      state_r   <= e_wait;
      pc_r      <= '0;
      credits_r <= credit_bits'(`QUEUE_CREDITS);
    end
    else
    begin
      state_r   <= state_n;
      pc_r      <= pc_n;
      credits_r <= credits_n;
    end
  end

  assign fetch_req_o = '{v: issue, pc: issue_pc, fault: issue_fault};

endmodule

/* source/fe_cmd_decode.sv */
// ----------------------------------------
// Front-end command decoder
// ----------------------------------------

`timescale 1ns/1ps

`include "fe_settings.svh"

module fe_cmd_decode
  (input  logic                          clk_i
   , input  logic                        reset_i

   , input  fe_pkg::fe_cmd_s             fe_cmd_i
   , input  logic                        fe_cmd_v_i
   , output logic                        fe_cmd_yumi_o

   , output logic                        redirect_v_o
   , output logic [`VADDR_WIDTH-1:0]     redirect_pc_o
   , output fe_pkg::fe_fill_s            fill_o
   , output logic                        park_v_o
   );

  logic is_redirect, is_fill, is_park;
  logic redirect_v_r, fill_v_r, park_v_r;
  logic [`VADDR_WIDTH-1:0] vaddr_r;
  logic [`INSTR_WIDTH-1:0] instr_r;

  // Every offered command is taken at once
  assign fe_cmd_yumi_o = fe_cmd_v_i;

  assign is_redirect = (fe_cmd_i.opcode == fe_pkg::e_op_redirect);
  assign is_fill     = (fe_cmd_i.opcode == fe_pkg::e_op_fill);
  assign is_park     = (fe_cmd_i.opcode == fe_pkg::e_op_park);

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      redirect_v_r <= 1'b0;
      fill_v_r     <= 1'b0;
      park_v_r     <= 1'b0;
    end
    else
    begin
      redirect_v_r <= fe_cmd_v_i & is_redirect;
      fill_v_r     <= fe_cmd_v_i & is_fill;
      park_v_r     <= fe_cmd_v_i & is_park;
    end
  end

  // Operands shared by redirect target and fill address
  always_ff @(posedge clk_i)
  begin
    if (fe_cmd_v_i)
    begin
      vaddr_r <= fe_cmd_i.vaddr;
      instr_r <= fe_cmd_i.instr;
    end
  end

  assign redirect_v_o  = redirect_v_r;
  assign redirect_pc_o = vaddr_r;
  assign park_v_o      = park_v_r;
  assign fill_o        = '{v: fill_v_r, addr: vaddr_r, instr: instr_r};

endmodule

/* source/fe_pkg.sv */
// ----------------------------------------
// Front-end types
// ----------------------------------------

`include "fe_settings.svh"

package fe_pkg;

  typedef enum logic [1:0]
  {
    e_op_redirect = 2'd0
    , e_op_fill   = 2'd1
    , e_op_park   = 2'd2
  } fe_opcode_e;

  // Instr field only matters for a fill
  typedef struct packed
  {
    fe_opcode_e              opcode;
    logic [`VADDR_WIDTH-1:0] vaddr;
    logic [`INSTR_WIDTH-1:0] instr;
  } fe_cmd_s;

  typedef struct packed
  {
    logic                    v;
    logic [`VADDR_WIDTH-1:0] addr;
    logic [`INSTR_WIDTH-1:0] instr;
  } fe_fill_s;

  typedef enum logic [1:0]
  {
    e_fault_none         = 2'd0
    , e_fault_misaligned = 2'd1
    , e_fault_access     = 2'd2
  } fe_fault_e;

  typedef struct packed
  {
    logic                    v;
    logic [`VADDR_WIDTH-1:0] pc;
    fe_fault_e               fault;
  } fe_fetch_req_s;

  typedef struct packed
  {
    logic                    v;
    logic [`VADDR_WIDTH-1:0] pc;
    logic [`INSTR_WIDTH-1:0] instr;
    fe_fault_e               fault;
  } fe_bank_resp_s;

  typedef enum logic
  {
    e_msg_fetch       = 1'b0
    , e_msg_exception = 1'b1
  } fe_msg_type_e;

  typedef struct packed
  {
    logic [`VADDR_WIDTH-1:0] pc;
    logic [`INSTR_WIDTH-1:0] instr;
  } fe_fetch_payload_s;

  // Pad keeps the exception view as wide as the fetch view
  typedef struct packed
  {
    logic [`VADDR_WIDTH-1:0] pc;
    fe_fault_e               fault;
    logic [`INSTR_WIDTH-3:0] pad;
  } fe_exception_payload_s;

  typedef union packed
  {
    fe_fetch_payload_s     fetch;
    fe_exception_payload_s exception;
  } fe_payload_u;

  typedef struct packed
  {
    fe_msg_type_e msg_type;
    fe_payload_u  payload;
  } fe_queue_msg_s;

endpackage

/* include/fe_settings.svh */
// ----------------------------------------
// Front-end size settings
// ----------------------------------------

`ifndef FE_SETTINGS_SVH
`define FE_SETTINGS_SVH

// PC and instruction widths
`define VADDR_WIDTH 32
`define INSTR_WIDTH 32

// Interleaved instruction store with power-of-two counts
`define IMEM_BANKS 4
`define BANK_WORDS 16

// One credit per entry of the back-end queue
`define QUEUE_CREDITS 4

`endif
